/* files.f */
logic/cpu_pkg.sv
logic/mem_result.sv
logic/reg_execute.sv
logic/fetch_decode.sv
logic/cpu_top.sv
sim/tb_cpu.sv

/* run_sim.sh */
#!/bin/sh
# builds tb_cpu with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -f files.f --top-module tb_cpu -o tb_cpu_sim; then
  echo "verilator build failed"
  exit 1
fi

if ! ./obj_dir/tb_cpu_sim > "$LOG" 2>&1; then
  cat "$LOG"
  echo "simulation exited with an error status"
  exit 1
fi
cat "$LOG"

if grep -q "SOME TESTS FAILED" "$LOG"; then
  exit 1
fi
exit 0

/* sim/cpu_stim.mem */
// program word count, then program words from word 46 (opcode/reg word, operand word)
// then expected store count, then store address/data pairs in program order
002C
// immediate stores, reg byte 12 selects r2
0401 0005  0301 0100   // r1 = 5, mem[100] = r1
0412 BEEF  0302 0101   // r2 = beef, mem[101] = r2
// arithmetic with wraparound
0501 0003  0301 0110   // r1 += 3, mem[110] = r1
0601 000A  0301 0111   // r1 -= a wraps to fffe, mem[111] = r1
0502 4112  0302 0112   // r2 += 4112 wraps to 1, mem[112] = r2
// load path from words written above
0203 0101  0303 0120   // r3 = mem[101], mem[120] = r3
0204 0111  0504 0003   // r4 = mem[111], r4 += 3
0304 0121              // mem[121] = r4
// jump over a store and unknown opcodes
0100 0050  0301 0130   // jmp 50 skips the store at 4e
7F01 1234  0301 0131   // unknown opcode, mem[131] = r1
FF02 5555  0302 0132   // unknown opcode, mem[132] = r2
0100 0058              // self-jump at 58, end of program
0009
0100 0005  0101 BEEF  0110 0008
0111 FFFE  0112 0001  0120 BEEF
0121 0001  0131 FFFE  0132 0001

/* sim/tb_cpu.sv */
`timescale 1ns/1ns

module tb_cpu;

  localparam int MEM_DEPTH       = 1024;
  localparam int STIM_DEPTH      = 128;
  localparam int PROG_BASE       = 46;    // first instruction word after reset
  localparam int RESET_CYCLES    = 8;
  localparam int CYCLES_PER_WORD = 20;    // watchdog budget per program word

  bit          clka;
  logic        rst;
  logic        mem_re;
  logic [9:0]  mem_raddr;
  logic [15:0] mem_rdata;
  logic        mem_we;
  logic [9:0]  mem_waddr;
  logic [15:0] mem_wdata;

  logic [15:0] stim [STIM_DEPTH];
  logic [15:0] mem [MEM_DEPTH];
  logic        rd_pend;
  logic [9:0]  rd_addr;
  int          prog_len;
  int          st_count;
  int          st_base;
  int          halt_addr;
  int          writes_seen;
  int          halt_reads;
  int          checks [1:5];
  int          errs [1:5];
  int          total_checks;
  int          total_errs;
  bit          first_read_seen;
  bit          halted;

  cpu_top dut_i (
    .clka      (clka),
    .rst       (rst),
    .mem_re    (mem_re),
    .mem_raddr (mem_raddr),
    .mem_rdata (mem_rdata),
    .mem_we    (mem_we),
    .mem_waddr (mem_waddr),
    .mem_wdata (mem_wdata)
  );

  function automatic string test_name(input int n);
    case (n)
      1: return "reset state";
      2: return "immediate stores";
      3: return "arithmetic";
      4: return "load path";
      default: return "jumps and unknown opcodes";
    endcase
  endfunction

  task automatic report_test(input int n);
    $display("test %0d %s: %0d checks, %0d errors, %s", n, test_name(n),
             checks[n], errs[n], (errs[n] == 0) ? "ok" : "failing");
  endtask

  task automatic value_error(input int t, input string sig, input logic [15:0] got,
                             input logic [15:0] exp_val);
    $display("Error at %0t ns: %s = %h, expected %h", $time, sig, got, exp_val);
    errs[t]++;
  endtask

  // compare one write strobe against the next trace entry
  task automatic check_store();
    int          idx;
    int          t;
    logic [15:0] exp_addr;
    logic [15:0] exp_data;
    idx = st_base + 2 * writes_seen;
    writes_seen++;
    assert (writes_seen <= st_count) else begin
      $display("write to address %h at %0t ns is beyond the expected trace", mem_waddr, $time);
      checks[5]++;
      errs[5]++;
    end
    if (writes_seen <= st_count) begin
      exp_addr = stim[idx];
      exp_data = stim[idx + 1];
      t = 2 + int'(exp_addr[5:4]);          // 16-word data block per behavior from 100
      checks[t] += 2;
      assert (mem_waddr == exp_addr[9:0])
        else value_error(t, "mem_waddr", 16'(mem_waddr), exp_addr);
      assert (mem_wdata == exp_data)
        else value_error(t, "mem_wdata", mem_wdata, exp_data);
    end
  endtask

  initial begin
    clka = 1'b0;
    forever #4 clka = ~clka;
  end

  // word memory, one cycle read latency, inputs change on the falling edge
  initial begin : memory_model
    mem_rdata = '0;
    rd_pend   = 1'b0;
    rd_addr   = '0;
    $readmemh("sim/cpu_stim.mem", stim);
    prog_len  = int'(stim[0]);
    st_count  = int'(stim[prog_len + 1]);
    st_base   = prog_len + 2;
    halt_addr = PROG_BASE + prog_len - 2;   // first word of the closing self-jump
    for (int a = 0; a < MEM_DEPTH; a++) begin
      mem[a] = {6'h2d, 10'(a)};
    end
    for (int i = 0; i < prog_len; i++) begin
      mem[PROG_BASE + i] = stim[1 + i];
    end
    forever begin
      @(negedge clka);
      if (rd_pend) begin
        mem_rdata = mem[rd_addr];           // data for last cycle's request
      end
      if (mem_we) begin
        mem[mem_waddr] = mem_wdata;
      end
      rd_pend = mem_re;
      rd_addr = mem_raddr;
    end
  end

  always @(negedge clka) begin
    if (!rst) begin
      checks[1]++;
      assert (!mem_we && !mem_re) else begin
        $display("memory strobe raised during reset at %0t ns", $time);
        errs[1]++;
      end
    end else if (!halted) begin
      if (mem_re && !first_read_seen) begin
        first_read_seen = 1'b1;
        checks[1]++;
        assert (mem_raddr == 10'(PROG_BASE))
          else value_error(1, "mem_raddr", 16'(mem_raddr), 16'(PROG_BASE));
        report_test(1);
      end
      if (mem_we) begin
        check_store();
      end
      if (mem_re && mem_raddr == 10'(halt_addr)) begin
        halt_reads++;
      end
      if (halt_reads == 2) begin            // self-jump has executed once
        checks[5]++;
        assert (writes_seen == st_count) else begin
          $display("Error at %0t ns: write count = %0d, expected %0d",
                   $time, writes_seen, st_count);
          errs[5]++;
        end
        halted = 1'b1;
      end
    end
  end

  initial begin
    rst = 1'b0;
    repeat (RESET_CYCLES) @(negedge clka);
    rst <= 1'b1;
    wait (halted);
    for (int n = 2; n <= 5; n++) begin
      report_test(n);
    end
    for (int n = 1; n <= 5; n++) begin
      total_checks += checks[n];
      total_errs   += errs[n];
    end
    $display("tests 5, checks %0d, errors %0d", total_checks, total_errs);
    if (total_errs == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    #1;
    repeat (RESET_CYCLES + prog_len * CYCLES_PER_WORD) @(posedge clka);
    $display("watchdog expired, program of %0d words never reached its self-jump", prog_len);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

/* logic/cpu_top.sv */
`timescale 1ns/1ns

module cpu_top import cpu_pkg::*; (
  input  logic  clka,
  input  logic  rst,
  output logic  mem_re,
  output addr_t mem_raddr,
  input  word_t mem_rdata,
  output logic  mem_we,
  output addr_t mem_waddr,
  output word_t mem_wdata
);

  logic      fetch_re;
  addr_t     fetch_addr;
  logic      op_valid;
  op_class_t op_class;
  reg_idx_t  op_reg;
  word_t     op_operand;
  logic      exec_done;
  logic      ld_req;
  logic      st_req;
  addr_t     ls_addr;
  word_t     st_data;
  logic      ld_valid;
  word_t     ld_data;

  fetch_decode fetch_decode_i (
    .clka       (clka),
    .rst        (rst),
    .mem_rdata  (mem_rdata),
    .exec_done  (exec_done),
    .fetch_re   (fetch_re),
    .fetch_addr (fetch_addr),
    .op_valid   (op_valid),
    .op_class   (op_class),
    .op_reg     (op_reg),
    .op_operand (op_operand)
  );

  reg_execute reg_execute_i (
    .clka       (clka),
    .rst        (rst),
    .op_valid   (op_valid),
    .op_class   (op_class),
    .op_reg     (op_reg),
    .op_operand (op_operand),
    .ld_valid   (ld_valid),
    .ld_data    (ld_data),
    .ld_req     (ld_req),
    .st_req     (st_req),
    .ls_addr    (ls_addr),
    .st_data    (st_data),
    .exec_done  (exec_done)
  );

  mem_result mem_result_i (
    .clka       (clka),
    .rst        (rst),
    .fetch_re   (fetch_re),
    .fetch_addr (fetch_addr),
    .ld_req     (ld_req),
    .st_req     (st_req),
    .ls_addr    (ls_addr),
    .st_data    (st_data),
    .mem_rdata  (mem_rdata),
    .mem_re     (mem_re),
    .mem_raddr  (mem_raddr),
    .mem_we     (mem_we),
    .mem_waddr  (mem_waddr),
    .mem_wdata  (mem_wdata),
    .ld_valid   (ld_valid),
    .ld_data    (ld_data)
  );

endmodule

/* logic/fetch_decode.sv */
`timescale 1ns/1ns

module fetch_decode import cpu_pkg::*; (
  input  logic      clka,
  input  logic      rst,
  input  word_t     mem_rdata,
  input  logic      exec_done,
  output logic      fetch_re,
  output addr_t     fetch_addr,
  output logic      op_valid,
  output op_class_t op_class,
  output reg_idx_t  op_reg,
  output word_t     op_operand
);

  fetch_state_t state;
  addr_t        pc;
  logic         running;                      // low for the first cycle out of reset
  opcode_t      opcode_q;
  reg_idx_t     reg_q;
  word_t        operand_q;
  logic         is_jmp;

  // opcode to execute class
  always_comb begin
    case (opcode_q)
      OP_NUM2REG:   op_class = CLS_SET;
      OP_REG_PLUS:  op_class = CLS_ADD;
      OP_REG_MINUS: op_class = CLS_SUB;
      OP_RAM2REG:   op_class = CLS_LOAD;
      OP_REG2RAM:   op_class = CLS_STORE;
      default:      op_class = CLS_NONE;      // jmp and unknown opcodes
    endcase
  end

  assign is_jmp = (opcode_q == OP_JMP);

  assign fetch_re   = running && (state == FETCH_HI || state == FETCH_LO);
  assign fetch_addr = (state == FETCH_LO) ? pc + addr_t'(1) : pc;

  assign op_valid = (state == DISPATCH) && (op_class != CLS_NONE);
  assign op_reg   = reg_q;

  // operand arrives during dispatch, held afterwards until retire
  assign op_operand = (state == DISPATCH) ? mem_rdata : operand_q;

  always_ff @(posedge clka) begin
    if (!rst) begin
      state    <= FETCH_HI;
      pc       <= PROGRAM_START;
      running  <= 1'b0;
      opcode_q <= '0;
    end else begin
      running <= 1'b1;
      case (state)
        FETCH_HI: begin
          if (running) begin
            state <= FETCH_LO;
          end
        end
        FETCH_LO: begin
          opcode_q <= mem_rdata[15:8];          // high byte is the opcode
          state    <= DISPATCH;
        end
        DISPATCH: begin
          if (is_jmp) begin
            pc <= mem_rdata[ADDR_W-1:0];
          end else begin
            pc <= pc + addr_t'(2);              // next two-word instruction
          end
          if (op_class == CLS_NONE) begin
            state <= FETCH_HI;
          end else begin
            state <= WAIT_DONE;
          end
        end
        WAIT_DONE: begin
          if (exec_done) begin
            state <= FETCH_HI;
          end
        end
        default: state <= FETCH_HI;
      endcase
    end
  end

  always_ff @(posedge clka) begin
    if (state == FETCH_LO) begin
      reg_q <= mem_rdata[REG_IDX_W-1:0];      // upper nibble of reg byte ignored
    end
    if (state == DISPATCH) begin
      operand_q <= mem_rdata;
    end
  end

  // execute retires only while an instruction is outstanding
  assert property (@(posedge clka) disable iff (!rst)
    exec_done |-> (state == WAIT_DONE));

endmodule

/* logic/reg_execute.sv */
`timescale 1ns/1ns

module reg_execute import cpu_pkg::*; (
  input  logic      clka,
  input  logic      rst,
  input  logic      op_valid,
  input  op_class_t op_class,
  input  reg_idx_t  op_reg,
  input  word_t     op_operand,
  input  logic      ld_valid,
  input  word_t     ld_data,
  output logic      ld_req,
  output logic      st_req,
  output addr_t     ls_addr,
  output word_t     st_data,
  output logic      exec_done
);

  word_t regs [NUM_REGS];
  logic  ld_pending;                          // load issued, waiting for data

  // op_reg and op_operand hold until exec_done
  assign ls_addr = op_operand[ADDR_W-1:0];
  assign st_data = regs[op_reg];

  always_ff @(posedge clka) begin
    if (!rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
      ld_req     <= 1'b0;
      st_req     <= 1'b0;
      exec_done  <= 1'b0;
      ld_pending <= 1'b0;
    end else begin
      ld_req    <= 1'b0;
      st_req    <= 1'b0;
      exec_done <= 1'b0;
      if (op_valid) begin
        case (op_class)
          CLS_SET: begin
            regs[op_reg] <= op_operand;
            exec_done    <= 1'b1;
          end
          CLS_ADD: begin
            regs[op_reg] <= regs[op_reg] + op_operand;  // wraps mod 2^16
            exec_done    <= 1'b1;
          end
          CLS_SUB: begin
            regs[op_reg] <= regs[op_reg] - op_operand;
            exec_done    <= 1'b1;
          end
          CLS_LOAD: begin
            ld_req     <= 1'b1;
            ld_pending <= 1'b1;
          end
          CLS_STORE: begin
            st_req    <= 1'b1;
            exec_done <= 1'b1;                // write lands one cycle later
          end
          default: ;
        endcase
      end
      if (ld_valid && ld_pending) begin
        regs[op_reg] <= ld_data;
        exec_done    <= 1'b1;
        ld_pending   <= 1'b0;
      end
    end
  end

  assert property (@(posedge clka) disable iff (!rst)
    !(ld_req && st_req));

  // load data only comes back for a load this side asked for
  assert property (@(posedge clka) disable iff (!rst)
    ld_valid |-> ld_pending);

endmodule

/* logic/mem_result.sv */
`timescale 1ns/1ns

module mem_result import cpu_pkg::*; (
  input  logic  clka,
  input  logic  rst,
  input  logic  fetch_re,
  input  addr_t fetch_addr,
  input  logic  ld_req,
  input  logic  st_req,
  input  addr_t ls_addr,
  input  word_t st_data,
  input  word_t mem_rdata,
  output logic  mem_re,
  output addr_t mem_raddr,
  output logic  mem_we,
  output addr_t mem_waddr,
  output word_t mem_wdata,
  output logic  ld_valid,
  output word_t ld_data
);

  logic  ld_rd_q;                             // load read on the port this cycle
  addr_t ld_addr_q;
  logic  st_q;
  addr_t st_addr_q;
  word_t st_data_q;

  // single read port shared by fetch and loads
  assign mem_re    = fetch_re || ld_rd_q;
  assign mem_raddr = ld_rd_q ? ld_addr_q : fetch_addr;

  assign mem_we    = st_q;
  assign mem_waddr = st_addr_q;
  assign mem_wdata = st_data_q;

  assign ld_data = mem_rdata;                 // valid alongside ld_valid

  always_ff @(posedge clka) begin
    if (!rst) begin
      ld_rd_q  <= 1'b0;
      st_q     <= 1'b0;
      ld_valid <= 1'b0;
    end else begin
      ld_rd_q  <= ld_req;
      st_q     <= st_req;
      ld_valid <= ld_rd_q;                    // one cycle read latency
    end
  end

  always_ff @(posedge clka) begin
    if (ld_req) begin
      ld_addr_q <= ls_addr;
    end
    if (st_req) begin
      st_addr_q <= ls_addr;
      st_data_q <= st_data;
    end
  end

  // fetch is idle while a load is in flight
  assert property (@(posedge clka) disable iff (!rst)
    !(fetch_re && ld_rd_q));

endmodule

/* logic/cpu_pkg.sv */
package cpu_pkg;

  localparam int WORD_W    = 16;
  localparam int ADDR_W    = 10;              // low bits of the operand address memory
  localparam int OPCODE_W  = 8;
  localparam int REG_IDX_W = 4;               // low nibble of the register byte

  typedef logic [WORD_W-1:0]    word_t;       // data, instruction or operand word
  typedef logic [ADDR_W-1:0]    addr_t;       // memory word address
  typedef logic [OPCODE_W-1:0]  opcode_t;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;

  localparam int NUM_REGS = 16;

  // first instruction after reset, past the old process header area
  localparam addr_t PROGRAM_START = 10'd46;

  localparam opcode_t OP_JMP       = 8'd1;    // pc = operand
  localparam opcode_t OP_RAM2REG   = 8'd2;    // reg = mem[operand]
  localparam opcode_t OP_REG2RAM   = 8'd3;    // mem[operand] = reg
  localparam opcode_t OP_NUM2REG   = 8'd4;    // reg = operand
  localparam opcode_t OP_REG_PLUS  = 8'd5;    // reg += operand
  localparam opcode_t OP_REG_MINUS = 8'd6;    // reg -= operand

  typedef enum logic [1:0] {
    FETCH_HI,                                 // request opcode word
    FETCH_LO,                                 // take opcode word, request operand
    DISPATCH,                                 // take operand, jump or hand off
    WAIT_DONE                                 // instruction in flight
  } fetch_state_t;

  typedef enum logic [2:0] {
    CLS_NONE,                                 // nothing for execute to do
    CLS_SET,
    CLS_ADD,
    CLS_SUB,
    CLS_LOAD,
    CLS_STORE
  } op_class_t;

endpackage
